// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_resp_top
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass message appears in the output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
resp_pkg.sv
resp_apb_regs.sv
resp_hex_formatter.sv
resp_uart_tx.sv
resp_top.sv
resp_chk.sv
tb_resp_top.sv

// File: resp_apb_regs.sv
`timescale 1ns/1ps
// APB register block with header words, data word queue and start command qualification
module resp_apb_regs (
	input  logic             clk,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  resp_pkg::paddr_t paddr,
	input  resp_pkg::word_t  pwdata,
	input  logic             busy,
	input  logic             done,
	input  logic             fifo_pop,
	output resp_pkg::word_t  prdata,
	output logic             pready,
	output logic             pslverr,
	output logic             start,
	output resp_pkg::word_t  status_word,
	output resp_pkg::word_t  addr_word,
	output resp_pkg::word_t  fifo_data,
	output logic             fifo_empty
);
	import resp_pkg::*;

	// queue storage and bookkeeping
	word_t fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LEVEL_W-1:0] level;
	logic fifo_full;

	// sticky end of response flag
	logic done_flag;

	// access qualification
	logic access;
	logic wr_access;
	logic running;
	logic err;
	logic push_ok;
	logic start_ok;

	assign access = psel & penable;
	assign wr_access = access & pwrite;
	// start pulse counts as running before busy rises
	assign running = busy | start;

	assign fifo_full = (level == LEVEL_W'(FIFO_DEPTH));
	assign fifo_empty = (level == '0);
	// head of queue
	assign fifo_data = fifo_mem[rd_ptr];

	// no wait states
	assign pready = 1'b1;

	// error decode per offset
	always_comb begin
		err = 1'b0;
		case (paddr)
			REG_STATUS_WORD: err = 1'b0;
			REG_ADDR_WORD: err = 1'b0;
			// push refused when full or mid send
			REG_DATA_PUSH: err = pwrite & (fifo_full | running);
			// start refused mid send or with nothing queued
			REG_CTRL: err = pwrite & pwdata[0] & (running | fifo_empty);
			// state is read only
			REG_STATE: err = pwrite;
			default: err = 1'b1;
		endcase
	end

	assign pslverr = access & err;
	assign push_ok = wr_access & ~err & (paddr == REG_DATA_PUSH);
	assign start_ok = wr_access & ~err & (paddr == REG_CTRL) & pwdata[0];

	// read mux
	always_comb begin
		prdata = '0;
		if (access & ~pwrite) begin
			case (paddr)
				REG_STATUS_WORD: prdata = status_word;
				REG_ADDR_WORD: prdata = addr_word;
				// level in 6:4, done in 1, busy in 0
				REG_STATE: prdata = {25'h0, level, 2'b00, done_flag, busy};
				default: prdata = '0;
			endcase
		end
	end

	// header registers
	always_ff @(posedge clk) begin
		if (rst) begin
			status_word <= '0;
			addr_word <= '0;
		end else if (wr_access) begin
			if (paddr == REG_STATUS_WORD)
				status_word <= pwdata;
			if (paddr == REG_ADDR_WORD)
				addr_word <= pwdata;
		end
	end

	// queue write port
	always_ff @(posedge clk) begin
		if (push_ok)
			fifo_mem[wr_ptr] <= pwdata;
	end

	// pointers wrap with the power of two depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (fifo_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, fifo_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// start pulse one cycle after the access phase
	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
			done_flag <= 1'b0;
		end else begin
			start <= start_ok;
			if (start_ok)
				done_flag <= 1'b0;
			else if (done)
				done_flag <= 1'b1;
		end
	end

endmodule

// File: resp_chk.sv
`timescale 1ns/1ps
// handshake and line checker bound into the response channel top
module resp_chk (
	input logic            clk,
	input logic            rst,
	input logic            psel,
	input logic            penable,
	input logic            pready,
	input resp_pkg::char_t tx_byte,
	input logic            tx_valid,
	input logic            tx_ready,
	input logic            fifo_pop,
	input logic            fifo_empty,
	input logic            txd
);
	// failed assertions so far
	int fail_count = 0;

	// character held until the serializer takes it
	a_byte_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
		else begin
			$error("tx_byte or tx_valid changed before tx_ready");
			fail_count++;
		end

	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst) !(fifo_pop && fifo_empty))
		else begin
			$error("fifo_pop with an empty queue");
			fail_count++;
		end

	// no wait states
	a_pready: assert property (@(posedge clk) disable iff (rst) psel && penable |-> pready)
		else begin
			$error("pready low in an access phase");
			fail_count++;
		end

	// idle line is high
	a_idle_line: assert property (@(posedge clk) disable iff (rst) tx_ready |-> txd)
		else begin
			$error("txd low while the serializer is idle");
			fail_count++;
		end

endmodule

bind resp_top resp_chk u_chk (
	.clk        (clk),
	.rst        (rst),
	.psel       (psel),
	.penable    (penable),
	.pready     (pready),
	.tx_byte    (tx_byte),
	.tx_valid   (tx_valid),
	.tx_ready   (tx_ready),
	.fifo_pop   (fifo_pop),
	.fifo_empty (fifo_empty),
	.txd        (txd)
);

// File: resp_hex_formatter.sv
`timescale 1ns/1ps
// hex formatter FSM that turns the header and queued words into an ASCII character stream
module resp_hex_formatter (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  resp_pkg::word_t status_word,
	input  resp_pkg::word_t addr_word,
	input  resp_pkg::word_t fifo_data,
	input  logic            fifo_empty,
	input  logic            tx_ready,
	output logic            fifo_pop,
	output resp_pkg::char_t tx_byte,
	output logic            tx_valid,
	output logic            busy,
	output logic            done
);
	import resp_pkg::*;

	// state names which word the offered character comes from
	typedef enum logic [2:0] {
		S_IDLE,
		S_SEND_S,
		S_STATUS,
		S_ADDRESS,
		S_DATA
	} state_t;

	state_t state;
	// address held until the status word is out
	word_t addr_q;
	// current word, top nibble is next
	word_t shift;
	// nibbles of the current word already offered
	logic [3:0] nib_cnt;
	logic accept;
	logic word_end;

	// nibble to upper case hex digit
	function automatic char_t hex_char(input logic [3:0] nib);
		char_t c;
		if (nib < 4'd10)
			c = CHAR_0 + {4'h0, nib};
		else
			c = CHAR_A_OFFSET + {4'h0, nib};
		return c;
	endfunction

	// character taken by the serializer this cycle
	assign accept = tx_valid & tx_ready;
	assign word_end = (nib_cnt == 4'(NIBBLES_PER_WORD));
	assign busy = (state != S_IDLE);

	// sequencing
	always_ff @(posedge clk) begin
		// single cycle strobes
		fifo_pop <= 1'b0;
		done <= 1'b0;
		if (rst) begin
			state <= S_IDLE;
			tx_valid <= 1'b0;
			nib_cnt <= '0;
			fifo_pop <= 1'b0;
			done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					// S goes out first
					if (start) begin
						state <= S_SEND_S;
						tx_valid <= 1'b1;
					end
				end
				S_SEND_S: begin
					if (accept) begin
						state <= S_STATUS;
						nib_cnt <= 4'd1;
					end
				end
				S_STATUS: begin
					if (accept) begin
						if (word_end) begin
							state <= S_ADDRESS;
							nib_cnt <= 4'd1;
						end else begin
							nib_cnt <= nib_cnt + 1'b1;
						end
					end
				end
				S_ADDRESS, S_DATA: begin
					if (accept) begin
						if (!word_end) begin
							nib_cnt <= nib_cnt + 1'b1;
						end else if (fifo_empty) begin
							// last character taken, frame complete
							state <= S_IDLE;
							tx_valid <= 1'b0;
							done <= 1'b1;
						end else begin
							// head word loaded now, drop it from the queue
							state <= S_DATA;
							nib_cnt <= 4'd1;
							fifo_pop <= 1'b1;
						end
					end
				end
				default: begin
					state <= S_IDLE;
					tx_valid <= 1'b0;
				end
			endcase
		end
	end

	// character and word datapath
	always_ff @(posedge clk) begin
		if (state == S_IDLE && start) begin
			shift <= status_word;
			addr_q <= addr_word;
			tx_byte <= CHAR_S;
		end else if (accept) begin
			if (state == S_SEND_S || !word_end) begin
				tx_byte <= hex_char(shift[31:28]);
				shift <= {shift[27:0], 4'h0};
			end else if (state == S_STATUS) begin
				tx_byte <= hex_char(addr_q[31:28]);
				shift <= {addr_q[27:0], 4'h0};
			end else begin
				// next queued word, unused when the queue ran dry
				tx_byte <= hex_char(fifo_data[31:28]);
				shift <= {fifo_data[27:0], 4'h0};
			end
		end
	end

endmodule

// File: resp_pkg.sv
// response channel package with shared types, register map, queue and serial constants
package resp_pkg;

	// status, address and data words
	typedef logic [31:0] word_t;
	// one ASCII character on the serial line
	typedef logic [7:0] char_t;
	// APB byte address
	typedef logic [4:0] paddr_t;

	// register offsets
	localparam paddr_t REG_STATUS_WORD = 5'h00;
	localparam paddr_t REG_ADDR_WORD = 5'h04;
	localparam paddr_t REG_DATA_PUSH = 5'h08;
	localparam paddr_t REG_CTRL = 5'h0C;
	localparam paddr_t REG_STATE = 5'h10;

	// data word queue
	localparam int FIFO_DEPTH = 4;
	localparam int LEVEL_W = 3;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// serial bit timing
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	// start bit, eight data bits and one stop bit
	localparam int FRAME_BITS = 10;

	// ASCII codes
	localparam char_t CHAR_S = 8'h53;
	localparam char_t CHAR_0 = 8'h30;
	// 'A' minus ten, added to nibbles 10 to 15
	localparam char_t CHAR_A_OFFSET = 8'h37;

	// hex digits per word
	localparam int NIBBLES_PER_WORD = 8;

endpackage

// File: resp_stim.txt
# W addr data err = write, R addr data err = read with expected data, all hex
# P err = push LCG word, S mode = send and check frame (1 probes APB mid frame), E name = end test
R 10 00000000 0
W 00 1234ABCD 0
W 04 9F0E7A56 0
R 00 1234ABCD 0
R 04 9F0E7A56 0
R 08 00000000 0
R 0C 00000000 0
E regs_reset
W 08 5EA7B0D2 0
R 10 00000010 0
S 0
R 10 00000002 0
E single_word
W 00 DEADBEEF 0
W 04 0042F00C 0
P 0
P 0
P 0
P 0
R 10 00000042 0
S 0
R 10 00000002 0
E four_words
W 0C 00000001 1
R 10 00000002 0
W 14 00000001 1
R 18 00000000 1
R 00 DEADBEEF 0
W 10 00000000 1
R 10 00000002 0
P 0
P 0
P 0
P 0
P 1
R 10 00000042 0
E error_cases
S 1
R 10 00000002 0
E during_send

// File: resp_top.sv
`timescale 1ns/1ps
// response channel top joining the APB register block, hex formatter and UART transmitter
module resp_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  resp_pkg::paddr_t paddr,
	input  resp_pkg::word_t  pwdata,
	output resp_pkg::word_t  prdata,
	output logic             pready,
	output logic             pslverr,
	output logic             txd
);
	import resp_pkg::*;

	// decode to execute
	logic start;
	word_t status_word;
	word_t addr_word;
	word_t fifo_data;
	logic fifo_empty;
	logic fifo_pop;
	logic busy;
	logic done;

	// execute to result
	char_t tx_byte;
	logic tx_valid;
	logic tx_ready;

	resp_apb_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.busy        (busy),
		.done        (done),
		.fifo_pop    (fifo_pop),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.start       (start),
		.status_word (status_word),
		.addr_word   (addr_word),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty)
	);

	resp_hex_formatter u_fmt (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.status_word (status_word),
		.addr_word   (addr_word),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty),
		.tx_ready    (tx_ready),
		.fifo_pop    (fifo_pop),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.busy        (busy),
		.done        (done)
	);

	resp_uart_tx u_tx (
		.clk      (clk),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.txd      (txd)
	);

endmodule

// File: resp_uart_tx.sv
`timescale 1ns/1ps
// UART transmitter sending one 8N1 character at a time on txd
module resp_uart_tx (
	input  logic            clk,
	input  logic            rst,
	input  resp_pkg::char_t tx_byte,
	input  logic            tx_valid,
	output logic            tx_ready,
	output logic            txd
);
	import resp_pkg::*;

	// frame in progress
	logic active;
	// cycles within the current bit
	logic [BIT_CNT_W-1:0] clk_cnt;
	// 0 start, 1 to 8 data, 9 stop
	logic [3:0] bit_idx;
	// data bits still to go, stop bit on top
	logic [8:0] shift;
	logic bit_end;

	// only idle takes a character
	assign tx_ready = ~active;
	assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// bit timing and line drive
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;
		end else if (!active) begin
			if (tx_valid) begin
				// start bit begins on the accept edge
				active <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
				txd <= 1'b0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_idx == 4'(FRAME_BITS - 1)) begin
				// stop bit done, line stays high
				active <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				txd <= shift[0];
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// shift register, LSB first
	always_ff @(posedge clk) begin
		if (!active && tx_valid)
			shift <= {1'b1, tx_byte};
		else if (active && bit_end)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

// File: tb_resp_top.sv
`timescale 1ns/1ps
// testbench for the response channel, driving APB from a stim file and decoding txd
module tb_resp_top;
	import resp_pkg::*;

	localparam int CLK_PERIOD = 40;
	// cycle limits for the wait loops
	localparam int APB_TIMEOUT = 16;
	localparam int CHAR_TIMEOUT = 200;
	// state reads allowed while waiting for the first pop of a send
	localparam int LEVEL_TIMEOUT = 1000;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	paddr_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;
	logic txd;

	// reference model
	word_t model_status;
	word_t model_addr;
	word_t model_q[$];
	char_t exp_chars[$];
	word_t lcg_state;

	int errors;
	int checks;
	int tests;
	int test_start_errors;

	resp_top DUT (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.txd     (txd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ends the run when the DUT stops answering
	task automatic timeout_fail(input string what);
		$display("timeout: %s at %0t", what, $time);
		$display("Errors found");
		$finish;
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_char(input char_t got, input char_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s pslverr expected %b got %b", $time, what, exp, got);
		end
	endtask

	// 32-bit LCG for queued data words
	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// one setup and one access phase, sampled mid-cycle in the access phase
	task automatic apb_access(input logic wr, input paddr_t a, input word_t d,
			output word_t rd, output logic err);
		int waited;
		waited = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = a;
		pwdata = d;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		while (pready !== 1'b1) begin
			waited++;
			if (waited > APB_TIMEOUT)
				timeout_fail("pready never rose");
			@(negedge clk);
			#(CLK_PERIOD / 4);
		end
		rd = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input paddr_t a, input word_t d, output logic err);
		word_t unused;
		apb_access(1'b1, a, d, unused, err);
	endtask

	task automatic apb_read(input paddr_t a, output word_t rd, output logic err);
		apb_access(1'b0, a, '0, rd, err);
	endtask

	// waits for a start bit, then samples each bit at its middle
	task automatic receive_char(output char_t c);
		int waited;
		int i;
		waited = 0;
		@(negedge clk);
		while (txd !== 1'b0) begin
			waited++;
			if (waited > CHAR_TIMEOUT)
				timeout_fail("no start bit on txd");
			@(negedge clk);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (txd !== 1'b0) begin
			errors++;
			$display("start bit on txd too short at %0t", $time);
		end
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			c[i] = txd;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (txd !== 1'b1) begin
			errors++;
			$display("stop bit on txd was low at %0t", $time);
		end
	endtask

	// eight hex digits, most significant nibble first
	function automatic void hex_word(input word_t w);
		logic [3:0] nib;
		for (int k = NIBBLES_PER_WORD - 1; k >= 0; k--) begin
			nib = 4'(w >> (4 * k));
			if (nib < 4'd10)
				exp_chars.push_back(CHAR_0 + {4'h0, nib});
			else
				exp_chars.push_back(CHAR_A_OFFSET + {4'h0, nib});
		end
	endfunction

	task automatic do_write(input paddr_t a, input word_t d, input logic e);
		logic err;
		apb_write(a, d, err);
		check_err(err, e, $sformatf("write to %h", a));
		// accepted writes update the model
		if (!e && a == REG_STATUS_WORD)
			model_status = d;
		if (!e && a == REG_ADDR_WORD)
			model_addr = d;
		if (!e && a == REG_DATA_PUSH)
			model_q.push_back(d);
	endtask

	// mode 1 also probes APB while the frame is on the line
	task automatic send_frame(input int mode);
		char_t got;
		word_t rd;
		logic err;
		int i;
		int polls;
		exp_chars.delete();
		exp_chars.push_back(CHAR_S);
		hex_word(model_status);
		hex_word(model_addr);
		foreach (model_q[j])
			hex_word(model_q[j]);
		apb_write(REG_CTRL, 32'h1, err);
		check_err(err, 1'b0, "start command");
		fork
			begin
				for (i = 0; i < exp_chars.size(); i++) begin
					receive_char(got);
					check_char(got, exp_chars[i], $sformatf("frame character %0d", i));
				end
			end
			begin
				if (mode != 0) begin
					// wait until a pop leaves room in the queue
					polls = 0;
					apb_read(REG_STATE, rd, err);
					while (rd[6:4] == LEVEL_W'(FIFO_DEPTH)) begin
						polls++;
						if (polls > LEVEL_TIMEOUT)
							timeout_fail("queue level stayed full during send");
						apb_read(REG_STATE, rd, err);
					end
					apb_write(REG_DATA_PUSH, lcg_next(), err);
					check_err(err, 1'b1, "push during send");
					apb_write(REG_CTRL, 32'h1, err);
					check_err(err, 1'b1, "start during send");
					apb_read(REG_STATE, rd, err);
					check_err(err, 1'b0, "state read during send");
					check_word(rd & 32'h1, 32'h1, "busy during send");
				end
			end
		join
		model_q.delete();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errors)
			$display("test %s passed", name);
		else
			$display("test %s failed with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	task automatic run_command(input string line);
		string cmd;
		string name;
		word_t a;
		word_t d;
		word_t rd;
		int e;
		int n;
		logic err;
		n = $sscanf(line, "%s", cmd);
		if (n < 1 || cmd.getc(0) == "#")
			return;
		if (cmd == "W") begin
			n = $sscanf(line, "%s %h %h %h", cmd, a, d, e);
			do_write(paddr_t'(a[4:0]), d, e[0]);
		end else if (cmd == "R") begin
			n = $sscanf(line, "%s %h %h %h", cmd, a, d, e);
			apb_read(paddr_t'(a[4:0]), rd, err);
			check_err(err, e[0], $sformatf("read of %h", a[4:0]));
			check_word(rd, d, $sformatf("read data of %h", a[4:0]));
		end else if (cmd == "P") begin
			n = $sscanf(line, "%s %h", cmd, e);
			do_write(REG_DATA_PUSH, lcg_next(), e[0]);
		end else if (cmd == "S") begin
			n = $sscanf(line, "%s %d", cmd, e);
			send_frame(e);
		end else if (cmd == "E") begin
			n = $sscanf(line, "%s %s", cmd, name);
			end_test(name);
		end else begin
			errors++;
			$display("unknown stimulus command %s", cmd);
		end
	endtask

	initial begin
		int fd;
		int n;
		string line;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start_errors = 0;
		model_status = '0;
		model_addr = '0;
		lcg_state = 32'hff93129d;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("resp_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open resp_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0)
					run_command(line);
			end
			$fclose(fd);
		end
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, checks, errors, DUT.u_chk.fail_count);
		if (errors == 0 && DUT.u_chk.fail_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
